// File: include/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data path and address width.
`define CORE_XLEN 32

// Architectural register file size.
`define CORE_NREGS 32

// Width of a register index.
`define CORE_RADDR_W 5

// Local data RAM depth in 32-bit words.
`define CORE_DMEM_WORDS 64

`endif

// File: design/core_pkg.sv
`default_nettype none

package core_pkg;

    // Decoded operation carried down the back end.
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,  // rj + rk.
        OP_SUB  = 4'd1,  // rj - rk.
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_ADDI = 4'd5,  // rj + imm.
        OP_LD_W = 4'd6,  // Load word at rj + imm.
        OP_ST_W = 4'd7,  // Store rk to rj + imm.
        OP_BAR  = 4'd8   // No write, asks the front end to refetch.
    } op_e;

    // Exception raised in the memory stage.
    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_ALE  = 2'd1,  // Address not word aligned.
        EXC_ADE  = 2'd2   // Word index past the end of the RAM.
    } excp_e;

    // True for every opcode that writes rd.
    function automatic logic has_wb(input op_e op);
        logic no_wb;
        no_wb = (op == OP_ST_W) || (op == OP_BAR);
        return !no_wb;
    endfunction

endpackage

`default_nettype wire

// File: design/pipe_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_cfg.svh"

interface pipe_if;

    logic                      valid;
    logic [`CORE_XLEN-1:0]     pc;
    core_pkg::op_e             op;
    logic [`CORE_RADDR_W-1:0]  rd;
    logic                      we;          // Opcode writes rd.
    logic [`CORE_XLEN-1:0]     result;      // ALU value, address or load data.
    logic [`CORE_XLEN-1:0]     store_data;
    core_pkg::excp_e           excp;

    modport src (
        output valid, pc, op, rd, we, result, store_data, excp
    );

    modport dst (
        input valid, pc, op, rd, we, result, store_data, excp
    );

endinterface

`default_nettype wire

// File: design/fwd_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_cfg.svh"

interface fwd_if;

    logic                      we;     // Valid, writing and fault free.
    logic [`CORE_RADDR_W-1:0]  waddr;
    logic [`CORE_XLEN-1:0]     wdata;
    logic [`CORE_XLEN-1:0]     pc;

    modport src (output we, waddr, wdata, pc);
    modport dst (input we, waddr, wdata, pc);

endinterface

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_cfg.svh"

module reg_file (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic [`CORE_RADDR_W-1:0]  rj_i,
    input  wire logic [`CORE_RADDR_W-1:0]  rk_i,
    output logic      [`CORE_XLEN-1:0]     rj_data_o,
    output logic      [`CORE_XLEN-1:0]     rk_data_o,
    fwd_if.dst                             commit_bus
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_bus.we && (commit_bus.waddr != '0)) begin
            regs[commit_bus.waddr] <= commit_bus.wdata;
        end
    end

    // r0 is hardwired to zero.
    assign rj_data_o = (rj_i == '0) ? '0 : regs[rj_i];
    assign rk_data_o = (rk_i == '0) ? '0 : regs[rk_i];

endmodule

`default_nettype wire

// File: design/exe_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_cfg.svh"

module exe_stage (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      advance_i,
    input  wire logic                      flush_i,
    input  wire logic                      issue_valid_i,
    input  wire logic [`CORE_XLEN-1:0]     issue_pc_i,
    input  wire core_pkg::op_e             issue_op_i,
    input  wire logic [`CORE_RADDR_W-1:0]  issue_rd_i,
    input  wire logic [`CORE_RADDR_W-1:0]  issue_rj_i,
    input  wire logic [`CORE_RADDR_W-1:0]  issue_rk_i,
    input  wire logic [`CORE_XLEN-1:0]     issue_imm_i,
    input  wire logic [`CORE_XLEN-1:0]     rj_data_i,
    input  wire logic [`CORE_XLEN-1:0]     rk_data_i,
    pipe_if.src                            ex2mem,
    pipe_if.dst                            mem2wb,
    fwd_if.dst                             commit_bus
);

    logic                  ex_fwd_ok;
    logic                  mem_fwd_ok;
    logic [`CORE_XLEN-1:0] rj_val;
    logic [`CORE_XLEN-1:0] rk_val;
    logic [`CORE_XLEN-1:0] op_b;
    logic                  use_imm;
    logic [`CORE_XLEN-1:0] alu_res;

    // A load in our own register has no data yet.
    assign ex_fwd_ok  = ex2mem.valid && ex2mem.we && (ex2mem.op != core_pkg::OP_LD_W);
    assign mem_fwd_ok = mem2wb.valid && mem2wb.we && (mem2wb.excp == core_pkg::EXC_NONE);

    always_comb begin
        if (issue_rj_i != '0 && ex_fwd_ok && ex2mem.rd == issue_rj_i) begin
            rj_val = ex2mem.result;
        end else if (issue_rj_i != '0 && mem_fwd_ok && mem2wb.rd == issue_rj_i) begin
            rj_val = mem2wb.result;
        end else if (issue_rj_i != '0 && commit_bus.we && commit_bus.waddr == issue_rj_i) begin
            rj_val = commit_bus.wdata;
        end else begin
            rj_val = rj_data_i;
        end
    end

    always_comb begin
        if (issue_rk_i != '0 && ex_fwd_ok && ex2mem.rd == issue_rk_i) begin
            rk_val = ex2mem.result;
        end else if (issue_rk_i != '0 && mem_fwd_ok && mem2wb.rd == issue_rk_i) begin
            rk_val = mem2wb.result;
        end else if (issue_rk_i != '0 && commit_bus.we && commit_bus.waddr == issue_rk_i) begin
            rk_val = commit_bus.wdata;
        end else begin
            rk_val = rk_data_i;
        end
    end

    assign use_imm = issue_op_i inside {core_pkg::OP_ADDI, core_pkg::OP_LD_W, core_pkg::OP_ST_W};
    assign op_b    = use_imm ? issue_imm_i : rk_val;

    always_comb begin
        case (issue_op_i)
            core_pkg::OP_SUB: alu_res = rj_val - op_b;
            core_pkg::OP_AND: alu_res = rj_val & op_b;
            core_pkg::OP_OR:  alu_res = rj_val | op_b;
            core_pkg::OP_XOR: alu_res = rj_val ^ op_b;
            core_pkg::OP_BAR: alu_res = '0;
            default:          alu_res = rj_val + op_b;  // ADD, ADDI and address.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            ex2mem.valid <= 1'b0;
        end else if (advance_i) begin
            ex2mem.valid <= issue_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            ex2mem.pc         <= issue_pc_i;
            ex2mem.op         <= issue_op_i;
            ex2mem.rd         <= issue_rd_i;
            ex2mem.we         <= core_pkg::has_wb(issue_op_i);
            ex2mem.result     <= alu_res;
            ex2mem.store_data <= rk_val;
            ex2mem.excp       <= core_pkg::EXC_NONE;
        end
    end

endmodule

`default_nettype wire

// File: design/mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_cfg.svh"

module mem_stage (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  advance_i,
    input  wire logic  flush_i,
    pipe_if.dst        ex2mem,
    pipe_if.src        mem2wb
);

    localparam int unsigned IDX_W = $clog2(`CORE_DMEM_WORDS);

    logic [`CORE_XLEN-1:0] dmem [`CORE_DMEM_WORDS];
    logic [IDX_W-1:0]      idx;
    logic                  is_mem;
    core_pkg::excp_e       excp;
    logic                  st_ok;
    logic [`CORE_XLEN-1:0] mem_result;

    assign idx    = ex2mem.result[IDX_W+1:2];
    assign is_mem = (ex2mem.op == core_pkg::OP_LD_W) || (ex2mem.op == core_pkg::OP_ST_W);

    always_comb begin
        excp = core_pkg::EXC_NONE;
        if (is_mem) begin
            if (ex2mem.result[1:0] != 2'b00) begin
                excp = core_pkg::EXC_ALE;
            end else if ((ex2mem.result >> 2) >= `CORE_DMEM_WORDS) begin
                excp = core_pkg::EXC_ADE;
            end
        end
    end

    assign st_ok = ex2mem.valid && (ex2mem.op == core_pkg::OP_ST_W) &&
                   (excp == core_pkg::EXC_NONE);

    assign mem_result = (ex2mem.op == core_pkg::OP_LD_W && excp == core_pkg::EXC_NONE) ?
                        dmem[idx] : ex2mem.result;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CORE_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (advance_i && !flush_i && st_ok) begin
            dmem[idx] <= ex2mem.store_data;  // Store lands at capture.
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            mem2wb.valid <= 1'b0;
        end else if (advance_i) begin
            mem2wb.valid <= ex2mem.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            mem2wb.pc         <= ex2mem.pc;
            mem2wb.op         <= ex2mem.op;
            mem2wb.rd         <= ex2mem.rd;
            mem2wb.we         <= ex2mem.we;
            mem2wb.result     <= mem_result;
            mem2wb.store_data <= ex2mem.store_data;
            mem2wb.excp       <= excp;
        end
    end

endmodule

`default_nettype wire

// File: design/wb_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_cfg.svh"

module wb_stage (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  advance_i,
    input  wire logic  flush_i,
    pipe_if.dst        mem2wb,
    fwd_if.src         commit_bus,
    output logic       commit_valid_o,
    output core_pkg::excp_e commit_excp_o,
    output logic       dcache_flush_o,
    output logic       store_commit_o
);

    logic                     valid_q;
    logic [`CORE_XLEN-1:0]    pc_q;
    logic [`CORE_RADDR_W-1:0] rd_q;
    logic                     we_q;
    logic [`CORE_XLEN-1:0]    wdata_q;
    core_pkg::excp_e          excp_q;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            valid_q <= 1'b0;
        end else if (advance_i) begin
            valid_q <= mem2wb.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            pc_q    <= mem2wb.pc;
            rd_q    <= mem2wb.rd;
            we_q    <= mem2wb.we;
            wdata_q <= mem2wb.result;
            excp_q  <= mem2wb.excp;
        end
    end

    // Faulted instructions commit but never write.
    assign commit_bus.we    = valid_q && we_q && (excp_q == core_pkg::EXC_NONE);
    assign commit_bus.waddr = rd_q;
    assign commit_bus.wdata = wdata_q;
    assign commit_bus.pc    = pc_q;

    assign commit_valid_o = valid_q;
    assign commit_excp_o  = excp_q;

    // Cache strobes look at the instruction about to commit.
    assign dcache_flush_o = mem2wb.valid &&
                            ((mem2wb.excp != core_pkg::EXC_NONE) || (mem2wb.op == core_pkg::OP_BAR));
    assign store_commit_o = mem2wb.valid && (mem2wb.op == core_pkg::OP_ST_W) &&
                            (mem2wb.excp == core_pkg::EXC_NONE);

endmodule

`default_nettype wire

// File: design/core_backend.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_cfg.svh"

module core_backend (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      advance_i,
    input  wire logic                      flush_i,
    input  wire logic                      issue_valid_i,
    input  wire logic [`CORE_XLEN-1:0]     issue_pc_i,
    input  wire core_pkg::op_e             issue_op_i,
    input  wire logic [`CORE_RADDR_W-1:0]  issue_rd_i,
    input  wire logic [`CORE_RADDR_W-1:0]  issue_rj_i,
    input  wire logic [`CORE_RADDR_W-1:0]  issue_rk_i,
    input  wire logic [`CORE_XLEN-1:0]     issue_imm_i,
    output logic                           commit_valid_o,
    output logic      [`CORE_XLEN-1:0]     commit_pc_o,
    output logic                           commit_we_o,
    output logic      [`CORE_RADDR_W-1:0]  commit_waddr_o,
    output logic      [`CORE_XLEN-1:0]     commit_wdata_o,
    output core_pkg::excp_e                commit_excp_o,
    output logic                           dcache_flush_o,
    output logic                           store_commit_o
);

    logic [`CORE_XLEN-1:0] rj_data;
    logic [`CORE_XLEN-1:0] rk_data;

    pipe_if ex2mem ();
    pipe_if mem2wb ();
    fwd_if  commit_bus ();

    reg_file reg_file_inst (
        .clk        (clk),
        .rst        (rst),
        .rj_i       (issue_rj_i),
        .rj_data_o  (rj_data),
        .rk_i       (issue_rk_i),
        .rk_data_o  (rk_data),
        .commit_bus (commit_bus)
    );

    exe_stage exe_stage_inst (
        .clk           (clk),
        .rst           (rst),
        .advance_i     (advance_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid_i),
        .issue_pc_i    (issue_pc_i),
        .issue_op_i    (issue_op_i),
        .issue_rd_i    (issue_rd_i),
        .issue_rj_i    (issue_rj_i),
        .issue_rk_i    (issue_rk_i),
        .issue_imm_i   (issue_imm_i),
        .rj_data_i     (rj_data),
        .rk_data_i     (rk_data),
        .ex2mem        (ex2mem),
        .mem2wb        (mem2wb),
        .commit_bus    (commit_bus)
    );

    mem_stage mem_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .advance_i (advance_i),
        .flush_i   (flush_i),
        .ex2mem    (ex2mem),
        .mem2wb    (mem2wb)
    );

    wb_stage wb_stage_inst (
        .clk            (clk),
        .rst            (rst),
        .advance_i      (advance_i),
        .flush_i        (flush_i),
        .mem2wb         (mem2wb),
        .commit_bus     (commit_bus),
        .commit_valid_o (commit_valid_o),
        .commit_excp_o  (commit_excp_o),
        .dcache_flush_o (dcache_flush_o),
        .store_commit_o (store_commit_o)
    );

    assign commit_pc_o    = commit_bus.pc;
    assign commit_we_o    = commit_bus.we;
    assign commit_waddr_o = commit_bus.waddr;
    assign commit_wdata_o = commit_bus.wdata;

endmodule

`default_nettype wire

// File: bench/core_props.sv
`timescale 1ns/10ps
`default_nettype none

module core_props (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic        advance_i,
    input wire logic        flush_i,
    input wire logic        commit_valid_i,
    input wire logic [31:0] commit_pc_i,
    input wire logic        commit_we_i,
    input wire logic [31:0] commit_wdata_i,
    input wire logic        dcache_flush_i,
    input wire logic        store_commit_i
);

    // A flush empties writeback on the same edge.
    property p_flush_clears_commit;
        @(posedge clk) disable iff (rst) flush_i |=> !commit_valid_i;
    endproperty

    property p_hold_when_stalled;
        @(posedge clk) disable iff (rst)
            (!advance_i && !flush_i) |=> ($stable(commit_valid_i) && $stable(commit_pc_i) &&
                                          $stable(commit_we_i) && $stable(commit_wdata_i) &&
                                          $stable(dcache_flush_i) && $stable(store_commit_i));
    endproperty

    property p_store_not_flushed;
        @(posedge clk) disable iff (rst) !(store_commit_i && dcache_flush_i);
    endproperty

    a_flush_clears_commit: assert property (p_flush_clears_commit)
        else $error("commit_valid_o high in the cycle after a flush");
    a_hold_when_stalled: assert property (p_hold_when_stalled)
        else $error("outputs changed while advance_i was low");
    a_store_not_flushed: assert property (p_store_not_flushed)
        else $error("store_commit_o and dcache_flush_o high together");

endmodule

bind core_backend core_props core_props_inst (
    .clk            (clk),
    .rst            (rst),
    .advance_i      (advance_i),
    .flush_i        (flush_i),
    .commit_valid_i (commit_valid_o),
    .commit_pc_i    (commit_pc_o),
    .commit_we_i    (commit_we_o),
    .commit_wdata_i (commit_wdata_o),
    .dcache_flush_i (dcache_flush_o),
    .store_commit_i (store_commit_o)
);

`default_nettype wire

// File: bench/tb_core_backend.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_cfg.svh"

module tb_core_backend;

    typedef struct {
        int            test;
        core_pkg::op_e op;
        logic [4:0]    rd;
        logic [4:0]    rj;
        logic [4:0]    rk;
        logic [31:0]   imm;
        logic          rand_imm;  // Replace imm by a random value.
        logic          flush;     // Assert flush_i on this issue.
        logic          idle;      // Random stall cycles before this issue.
    } row_t;

    typedef struct {
        logic            valid;
        logic [31:0]     pc;
        core_pkg::op_e   op;
        logic            we;
        logic [4:0]      waddr;
        logic [31:0]     wdata;
        core_pkg::excp_e excp;
        logic            undo;
        logic [31:0]     undo_val;
    } exp_t;

    logic                      clk;
    logic                      rst;
    logic                      advance_i;
    logic                      flush_i;
    logic                      issue_valid_i;
    logic [`CORE_XLEN-1:0]     issue_pc_i;
    core_pkg::op_e             issue_op_i;
    logic [`CORE_RADDR_W-1:0]  issue_rd_i;
    logic [`CORE_RADDR_W-1:0]  issue_rj_i;
    logic [`CORE_RADDR_W-1:0]  issue_rk_i;
    logic [`CORE_XLEN-1:0]     issue_imm_i;
    logic                      commit_valid_o;
    logic [`CORE_XLEN-1:0]     commit_pc_o;
    logic                      commit_we_o;
    logic [`CORE_RADDR_W-1:0]  commit_waddr_o;
    logic [`CORE_XLEN-1:0]     commit_wdata_o;
    core_pkg::excp_e           commit_excp_o;
    logic                      dcache_flush_o;
    logic                      store_commit_o;

    logic [31:0] mregs [32];  // Architectural state of the model.
    logic [31:0] mram [64];
    exp_t        slots [3];   // ex2mem, mem2wb, writeback.
    row_t        stim_q [$];
    string       test_name [7];
    logic [31:0] pc_ctr;
    int          errors;
    int          tests_failed;

    core_backend core_backend_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_excp(input string name, input core_pkg::excp_e got,
                              input core_pkg::excp_e exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic add_row(input int test, input core_pkg::op_e op, input logic [4:0] rd,
                           input logic [4:0] rj, input logic [4:0] rk, input logic [31:0] imm,
                           input logic rand_imm, input logic flush, input logic idle);
        row_t r;
        r.test     = test;
        r.op       = op;
        r.rd       = rd;
        r.rj       = rj;
        r.rk       = rk;
        r.imm      = imm;
        r.rand_imm = rand_imm;
        r.flush    = flush;
        r.idle     = idle;
        stim_q.push_back(r);
    endtask

    // Sequential reference of one instruction.
    task automatic model_issue(input row_t r, input logic [31:0] imm, output exp_t e);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        a    = mregs[r.rj];
        b    = mregs[r.rk];
        addr = a + imm;
        e.valid    = 1'b1;
        e.pc       = pc_ctr;
        e.op       = r.op;
        e.waddr    = r.rd;
        e.wdata    = addr;
        e.excp     = core_pkg::EXC_NONE;
        e.undo     = 1'b0;
        e.undo_val = mregs[r.rd];
        if (r.op == core_pkg::OP_LD_W || r.op == core_pkg::OP_ST_W) begin
            if (addr[1:0] != 2'b00) begin
                e.excp = core_pkg::EXC_ALE;
            end else if (addr[31:8] != 24'd0) begin
                e.excp = core_pkg::EXC_ADE;  // Word index 64 and up.
            end
        end
        case (r.op)
            core_pkg::OP_ADD:  e.wdata = a + b;
            core_pkg::OP_SUB:  e.wdata = a - b;
            core_pkg::OP_AND:  e.wdata = a & b;
            core_pkg::OP_OR:   e.wdata = a | b;
            core_pkg::OP_XOR:  e.wdata = a ^ b;
            core_pkg::OP_LD_W: begin
                if (e.excp == core_pkg::EXC_NONE) begin
                    e.wdata = mram[addr[7:2]];
                end
            end
            core_pkg::OP_ST_W: begin
                if (e.excp == core_pkg::EXC_NONE) begin
                    mram[addr[7:2]] = b;
                end
            end
            default: ;
        endcase
        e.we = (r.op != core_pkg::OP_ST_W) && (r.op != core_pkg::OP_BAR) &&
               (e.excp == core_pkg::EXC_NONE);
        if (e.we && r.rd != 5'd0) begin
            mregs[r.rd] = e.wdata;
            e.undo      = 1'b1;
        end
    endtask

    task automatic check_outputs();
        logic exp_flush;
        logic exp_store;
        if (slots[2].valid) begin
            check_bit("commit_valid_o", commit_valid_o, 1'b1);
            check_word("commit_pc_o", commit_pc_o, slots[2].pc);
            check_bit("commit_we_o", commit_we_o, slots[2].we);
            check_excp("commit_excp_o", commit_excp_o, slots[2].excp);
            if (slots[2].we) begin
                check_word("commit_waddr_o", {27'd0, commit_waddr_o}, {27'd0, slots[2].waddr});
                check_word("commit_wdata_o", commit_wdata_o, slots[2].wdata);
            end
        end else begin
            check_bit("commit_valid_o", commit_valid_o, 1'b0);
            check_bit("commit_we_o", commit_we_o, 1'b0);
        end
        // Strobes belong to the instruction one advance behind writeback.
        exp_flush = slots[1].valid &&
                    (slots[1].excp != core_pkg::EXC_NONE || slots[1].op == core_pkg::OP_BAR);
        exp_store = slots[1].valid && slots[1].op == core_pkg::OP_ST_W &&
                    slots[1].excp == core_pkg::EXC_NONE;
        check_bit("dcache_flush_o", dcache_flush_o, exp_flush);
        check_bit("store_commit_o", store_commit_o, exp_store);
    endtask

    task automatic issue_step(input logic vld, input row_t r);
        logic [31:0] imm;
        int          n;
        exp_t        e;
        imm = r.rand_imm ? $urandom : r.imm;
        n   = (vld && r.idle) ? $urandom_range(3, 0) : 0;
        for (int i = 0; i < n; i++) begin
            advance_i     = 1'b0;
            issue_valid_i = 1'b0;
            @(negedge clk);
        end
        advance_i     = 1'b1;
        flush_i       = vld && r.flush;
        issue_valid_i = vld;
        issue_pc_i    = pc_ctr;
        issue_op_i    = r.op;
        issue_rd_i    = r.rd;
        issue_rj_i    = r.rj;
        issue_rk_i    = r.rk;
        issue_imm_i   = imm;
        @(negedge clk);
        if (vld && r.flush) begin
            // Younger first, so the register keeps its oldest value.
            for (int s = 0; s < 2; s++) begin
                if (slots[s].valid && slots[s].undo) begin
                    mregs[slots[s].waddr] = slots[s].undo_val;
                end
            end
            for (int s = 0; s < 3; s++) begin
                slots[s].valid = 1'b0;
            end
        end else begin
            e.valid = 1'b0;
            e.op    = core_pkg::OP_ADD;
            e.excp  = core_pkg::EXC_NONE;
            if (vld) begin
                model_issue(r, imm, e);
            end
            slots[2] = slots[1];
            slots[1] = slots[0];
            slots[0] = e;
        end
        if (vld) begin
            pc_ctr += 32'd4;
        end
        check_outputs();
        advance_i     = 1'b0;
        flush_i       = 1'b0;
        issue_valid_i = 1'b0;
    endtask

    task automatic drain();
        row_t nop;
        int   guard;
        nop.op       = core_pkg::OP_ADD;
        nop.rd       = 5'd0;
        nop.rj       = 5'd0;
        nop.rk       = 5'd0;
        nop.imm      = 32'd0;
        nop.rand_imm = 1'b0;
        nop.flush    = 1'b0;
        nop.idle     = 1'b0;
        guard        = 0;
        while ((slots[0].valid || slots[1].valid || slots[2].valid || commit_valid_o) &&
               guard < 10) begin
            issue_step(1'b0, nop);
            guard++;
        end
        if (guard >= 10) begin
            $display("Timeout: the pipeline kept committing after the last issue");
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic report_test(input int test, input int errors_before);
        if (errors == errors_before) begin
            $display("Test %0d %s: ok", test, test_name[test]);
        end else begin
            $display("Test %0d %s: FAILED with %0d errors", test, test_name[test],
                     errors - errors_before);
            tests_failed++;
        end
    endtask

    initial begin
        int cur_test;
        int errors_before;
        void'($urandom(32'h8a4f));
        rst = 1'b1;
        advance_i = 1'b0;
        flush_i = 1'b0;
        issue_valid_i = 1'b0;
        issue_pc_i = '0;
        issue_op_i = core_pkg::OP_ADD;
        issue_rd_i = '0;
        issue_rj_i = '0;
        issue_rk_i = '0;
        issue_imm_i = '0;
        pc_ctr = 32'h1c00_0000;
        errors = 0;
        tests_failed = 0;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            mram[i] = '0;
        end
        for (int s = 0; s < 3; s++) begin
            slots[s].valid = 1'b0;
            slots[s].op    = core_pkg::OP_ADD;
            slots[s].excp  = core_pkg::EXC_NONE;
        end
        test_name[1] = "alu and forwarding";
        test_name[2] = "store then load";
        test_name[3] = "address faults";
        test_name[4] = "barrier";
        test_name[5] = "flush in flight";
        test_name[6] = "random stalls";

        add_row(1, core_pkg::OP_ADDI, 1, 0, 0, 0, 1, 0, 0);
        add_row(1, core_pkg::OP_ADDI, 2, 0, 0, 0, 1, 0, 0);
        add_row(1, core_pkg::OP_ADD,  3, 1, 2, 0, 0, 0, 0);  // r1 from mem2wb, r2 from ex.
        add_row(1, core_pkg::OP_SUB,  4, 3, 1, 0, 0, 0, 0);  // r1 from commit bus.
        add_row(1, core_pkg::OP_AND,  5, 4, 2, 0, 0, 0, 0);
        add_row(1, core_pkg::OP_OR,   6, 5, 3, 0, 0, 0, 0);
        add_row(1, core_pkg::OP_XOR,  7, 6, 4, 0, 0, 0, 0);
        add_row(1, core_pkg::OP_ADD,  8, 7, 0, 0, 0, 0, 0);
        add_row(2, core_pkg::OP_ADDI, 9, 0, 0, 16, 0, 0, 0);
        add_row(2, core_pkg::OP_ST_W, 0, 9, 3, 4, 0, 0, 0);
        add_row(2, core_pkg::OP_ADDI, 10, 0, 0, 1, 0, 0, 0);
        add_row(2, core_pkg::OP_ADD,  11, 1, 2, 0, 0, 0, 0);
        add_row(2, core_pkg::OP_LD_W, 12, 9, 0, 4, 0, 0, 0);
        add_row(2, core_pkg::OP_ADDI, 13, 0, 0, 7, 0, 0, 0);
        add_row(2, core_pkg::OP_ADD,  14, 12, 13, 0, 0, 0, 0);
        add_row(3, core_pkg::OP_LD_W, 15, 9, 0, 2, 0, 0, 0);    // Misaligned.
        add_row(3, core_pkg::OP_ST_W, 0, 9, 1, 260, 0, 0, 0);   // Past the RAM.
        add_row(3, core_pkg::OP_ST_W, 0, 9, 1, 6, 0, 0, 0);
        add_row(3, core_pkg::OP_LD_W, 16, 0, 0, 32'h400, 0, 0, 0);
        add_row(3, core_pkg::OP_LD_W, 17, 9, 0, 4, 0, 0, 0);    // Word still holds r3.
        add_row(4, core_pkg::OP_BAR,  0, 0, 0, 0, 0, 0, 0);
        add_row(4, core_pkg::OP_ADD,  18, 17, 1, 0, 0, 0, 0);
        add_row(5, core_pkg::OP_ADDI, 20, 0, 0, 0, 1, 0, 0);
        add_row(5, core_pkg::OP_ADDI, 21, 20, 0, 1, 0, 0, 0);
        add_row(5, core_pkg::OP_ADDI, 22, 21, 0, 1, 0, 1, 0);
        add_row(5, core_pkg::OP_ADD,  23, 20, 21, 0, 0, 0, 0);
        add_row(5, core_pkg::OP_ADDI, 20, 0, 0, 3, 0, 0, 0);
        add_row(5, core_pkg::OP_ADD,  24, 20, 20, 0, 0, 0, 0);
        add_row(6, core_pkg::OP_ADDI, 25, 0, 0, 0, 1, 0, 1);
        add_row(6, core_pkg::OP_ADDI, 26, 0, 0, 0, 1, 0, 1);
        add_row(6, core_pkg::OP_ADD,  27, 25, 26, 0, 0, 0, 1);
        add_row(6, core_pkg::OP_XOR,  28, 27, 25, 0, 0, 0, 1);
        add_row(6, core_pkg::OP_ST_W, 0, 9, 28, 8, 0, 0, 1);
        add_row(6, core_pkg::OP_SUB,  29, 28, 26, 0, 0, 0, 1);
        add_row(6, core_pkg::OP_LD_W, 30, 9, 0, 8, 0, 0, 1);
        add_row(6, core_pkg::OP_ADDI, 31, 29, 0, 1, 0, 0, 1);
        add_row(6, core_pkg::OP_OR,   1, 30, 31, 0, 0, 0, 1);

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_outputs();

        cur_test = stim_q[0].test;
        errors_before = errors;
        foreach (stim_q[i]) begin
            if (stim_q[i].test != cur_test) begin
                drain();
                report_test(cur_test, errors_before);
                cur_test = stim_q[i].test;
                errors_before = errors;
            end
            issue_step(1'b1, stim_q[i]);
        end
        drain();
        report_test(cur_test, errors_before);

        $display("Tests run %0d, tests failed %0d, check errors %0d", cur_test, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
design/core_pkg.sv
design/pipe_if.sv
design/fwd_if.sv
design/reg_file.sv
design/exe_stage.sv
design/mem_stage.sv
design/wb_stage.sv
design/core_backend.sv
bench/core_props.sv
bench/tb_core_backend.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core_backend
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_STR)"

clean:
	rm -rf $(BUILD_DIR)
